// ==== verilog/memCtlPkg.sv ====
package memCtlPkg;

  typedef enum logic [3:0] {
    stIdle       = 4'd0,
    stAccess     = 4'd1, // data cycle on the RAM
    stWalkFirst  = 4'd2, // first page-table word in flight
    stWalkSecond = 4'd3, // second page-table word in flight
    stDone       = 4'd4,
    stFault      = 4'd5
  } mcStateE;

  typedef enum logic [1:0] {
    statusFault = 2'd0,
    statusBusy  = 2'd1,
    statusDone  = 2'd2
  } mcStatusE;

  // first page-table word carries the flags
  localparam int pteValidBit  = 31;
  localparam int pteNoExecBit = 30;

  localparam int vpnW    = 20;
  localparam int pfnW    = 20; // frame number sits in bits 19:0 of the second word
  localparam int offsetW = 12;
  localparam int tlbIdxW = 6;

  localparam int tlbTagW   = vpnW; // the whole page number is kept as tag
  localparam int tlbEntryW = 1 + tlbTagW + pfnW; // no-execute, tag, frame

endpackage

// ==== verilog/memReqLatch.sv ====
`timescale 1ns/1ps

module memReqLatch (
  input  logic        clk,
  input  logic        rstN,
  input  logic        readReq,
  input  logic        writeReq,
  input  logic [31:0] addr,
  input  logic [31:0] wrData,
  input  logic        addrVirtual,
  input  logic        execMode,
  input  logic        reqFinish,
  output logic        reqStart,
  output logic [31:0] reqAddr,
  output logic [31:0] reqData,
  output logic        reqIsRead,
  output logic        reqVirtual,
  output logic        reqExec
);

  logic held;
  logic accept;

  // the slot frees in the same cycle the walker finishes, so a strobe there is taken
  assign accept = (readReq || writeReq) && (!held || reqFinish);

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      held     <= 1'b0;
      reqStart <= 1'b0;
    end
    else
    begin
      reqStart <= accept;
      if (accept)
        held <= 1'b1;
      else if (reqFinish)
        held <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      reqAddr    <= addr;
      reqData    <= wrData;
      reqIsRead  <= readReq;
      reqVirtual <= addrVirtual;
      reqExec    <= execMode;
    end
  end

  aReadWriteExclusive: assert property (@(posedge clk) disable iff (!rstN)
    !(readReq && writeReq))
    else $error("read and write strobes raised together");

  aNoStrobeWhileHeld: assert property (@(posedge clk) disable iff (!rstN)
    (readReq || writeReq) |-> (!held || reqFinish))
    else $error("request strobe dropped, a request is still in flight");

endmodule

// ==== verilog/tlbCache.sv ====
`timescale 1ns/1ps

module tlbCache #(
  parameter int tlbEntries = 64
) (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic [31:0]                   lookupAddr,
  input  logic                          fillEn,
  input  logic [memCtlPkg::vpnW-1:0]    fillVpn,
  input  logic                          fillNoExec,
  input  logic [memCtlPkg::pfnW-1:0]    fillPfn,
  output logic                          hit,
  output logic                          hitNoExec,
  output logic [memCtlPkg::pfnW-1:0]    hitPfn
);

  localparam int entryW = memCtlPkg::tlbEntryW;
  localparam int pfnW   = memCtlPkg::pfnW;
  localparam int tagW   = memCtlPkg::tlbTagW;
  localparam int idxW   = memCtlPkg::tlbIdxW;

  logic [tlbEntries-1:0] validQ;
  logic [entryW-1:0]     entryQ [tlbEntries];
  logic [idxW-1:0]       lookupIdx;
  logic [idxW-1:0]       fillIdx;
  logic [tagW-1:0]       lookupTag;
  logic [entryW-1:0]     lookupEntry;

  if (tlbEntries != 2 ** memCtlPkg::tlbIdxW)
  begin : gDepthCheck
    $error("tlbCache depth must be 2**tlbIdxW");
  end

  // page number folded in six-bit slices, the offset stays out so a page has one slot
  function automatic logic [idxW-1:0] foldIdx(input logic [memCtlPkg::vpnW-1:0] vpn);
    logic [idxW-1:0] idx;
    idx = '0;
    for (int i = 0; i < memCtlPkg::vpnW; i += idxW)
      idx ^= idxW'(vpn >> i);
    return idx;
  endfunction

  assign lookupTag   = lookupAddr[31:memCtlPkg::offsetW];
  assign lookupIdx   = foldIdx(lookupTag);
  assign fillIdx     = foldIdx(fillVpn);
  assign lookupEntry = entryQ[lookupIdx];

  assign hit       = validQ[lookupIdx] && (lookupEntry[pfnW +: tagW] == lookupTag);
  assign hitNoExec = lookupEntry[entryW-1];
  assign hitPfn    = lookupEntry[pfnW-1:0];

  always_ff @(posedge clk)
  begin
    if (!rstN)
      validQ <= '0;
    else if (fillEn)
      validQ[fillIdx] <= 1'b1;
  end

  // a fill simply evicts whatever page shared the index
  always_ff @(posedge clk)
  begin
    if (fillEn)
      entryQ[fillIdx] <= {fillNoExec, fillVpn, fillPfn};
  end

endmodule

// ==== verilog/physMemPort.sv ====
`timescale 1ns/1ps

module physMemPort #(
  parameter int ramLatency = 2
) (
  input  logic        clk,
  input  logic        rstN,
  input  logic        memStart,
  input  logic [31:0] memAddr,
  input  logic [31:0] memData,
  input  logic        memIsRead,
  input  logic [31:0] phRdData,
  output logic        memDone,
  output logic [31:0] memRdData,
  output logic [31:0] phAddr,
  output logic [31:0] phWrData,
  output logic        phReadReq,
  output logic        phWriteReq
);

  localparam int cntW = $clog2(ramLatency + 1);

  logic [cntW-1:0] cnt;
  logic            readPend;
  logic            lastCycle;
  logic            lastIsRead;

  // the strobe rides on the start pulse, the walker keeps address and data steady
  assign phReadReq  = memStart && memIsRead;
  assign phWriteReq = memStart && !memIsRead;
  assign phAddr     = memAddr;
  assign phWrData   = memData;

  assign lastCycle  = memStart ? (ramLatency == 1) : (cnt == cntW'(1));
  assign lastIsRead = memStart ? memIsRead : readPend;

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      cnt      <= '0;
      readPend <= 1'b0;
      memDone  <= 1'b0;
    end
    else
    begin
      memDone <= lastCycle;
      if (memStart)
      begin
        cnt      <= cntW'(ramLatency - 1);
        readPend <= memIsRead;
      end
      else if (cnt != '0)
        cnt <= cnt - cntW'(1);
    end
  end

  always_ff @(posedge clk)
  begin
    if (lastCycle && lastIsRead)
      memRdData <= phRdData; // sampled on the same edge that raises memDone
  end

  aNoOverlap: assert property (@(posedge clk) disable iff (!rstN)
    memStart |-> (cnt == '0))
    else $error("RAM cycle started while the previous one is pending");

endmodule

// ==== verilog/pageWalkFsm.sv ====
`timescale 1ns/1ps

module pageWalkFsm (
  input  logic                          clk,
  input  logic                          rstN,
  input  logic                          reqStart,
  input  logic [31:0]                   reqAddr,
  input  logic [31:0]                   reqData,
  input  logic                          reqIsRead,
  input  logic                          reqVirtual,
  input  logic                          reqExec,
  input  logic [31:0]                   ptBase,
  input  logic                          hit,
  input  logic                          hitNoExec,
  input  logic [memCtlPkg::pfnW-1:0]    hitPfn,
  input  logic                          memDone,
  input  logic [31:0]                   memRdData,
  output logic                          reqFinish,
  output logic [31:0]                   lookupAddr,
  output logic                          fillEn,
  output logic [memCtlPkg::vpnW-1:0]    fillVpn,
  output logic                          fillNoExec,
  output logic [memCtlPkg::pfnW-1:0]    fillPfn,
  output logic                          memStart,
  output logic [31:0]                   memAddr,
  output logic [31:0]                   memData,
  output logic                          memIsRead,
  output logic [31:0]                   rdData,
  output memCtlPkg::mcStatusE           status
);

  localparam int offsetW = memCtlPkg::offsetW;

  memCtlPkg::mcStateE state;

  logic startNow;
  logic direct;
  logic pteValid;
  logic pteNoExec;
  logic walkFault;

  assign startNow = (state == memCtlPkg::stIdle) && reqStart;
  // physical requests and clean hits skip the walk
  assign direct   = !reqVirtual || (hit && !(hitNoExec && reqExec));
  assign walkFault = !pteValid || (pteNoExec && reqExec);

  assign lookupAddr = reqAddr;
  assign reqFinish  = (state == memCtlPkg::stDone) || (state == memCtlPkg::stFault);

  assign fillEn     = (state == memCtlPkg::stWalkSecond) && memDone && pteValid;
  assign fillVpn    = reqAddr[31:offsetW];
  assign fillNoExec = pteNoExec;
  assign fillPfn    = memRdData[memCtlPkg::pfnW-1:0];

  always_ff @(posedge clk)
  begin
    if (!rstN)
    begin
      state    <= memCtlPkg::stIdle;
      memStart <= 1'b0;
      status   <= memCtlPkg::statusDone;
    end
    else
    begin
      memStart <= 1'b0;
      case (state)
        memCtlPkg::stIdle:
          if (reqStart)
          begin
            status <= memCtlPkg::statusBusy;
            if (direct)
            begin
              state    <= memCtlPkg::stAccess;
              memStart <= 1'b1;
            end
            else if (hit)
              state <= memCtlPkg::stFault; // cached page is no-execute
            else
            begin
              state    <= memCtlPkg::stWalkFirst;
              memStart <= 1'b1;
            end
          end
        memCtlPkg::stAccess:
          if (memDone)
          begin
            state  <= memCtlPkg::stDone;
            status <= memCtlPkg::statusDone;
          end
        memCtlPkg::stWalkFirst:
          if (memDone)
          begin
            state    <= memCtlPkg::stWalkSecond;
            memStart <= 1'b1;
          end
        memCtlPkg::stWalkSecond:
          if (memDone)
          begin
            if (walkFault)
              state <= memCtlPkg::stFault;
            else
            begin
              state    <= memCtlPkg::stAccess;
              memStart <= 1'b1;
            end
          end
        memCtlPkg::stDone:
          state <= memCtlPkg::stIdle;
        memCtlPkg::stFault:
        begin
          state  <= memCtlPkg::stIdle;
          status <= memCtlPkg::statusFault;
        end
        default:
          state <= memCtlPkg::stIdle;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (startNow)
    begin
      memData <= reqData;
      if (!reqVirtual)
      begin
        memAddr   <= reqAddr;
        memIsRead <= reqIsRead;
      end
      else if (hit)
      begin
        memAddr   <= {hitPfn, reqAddr[offsetW-1:0]};
        memIsRead <= reqIsRead;
      end
      else
      begin
        memAddr   <= ptBase + {9'd0, reqAddr[31:offsetW], 3'd0}; // two words per entry
        memIsRead <= 1'b1;
      end
    end
    if ((state == memCtlPkg::stWalkFirst) && memDone)
    begin
      pteValid  <= memRdData[memCtlPkg::pteValidBit];
      pteNoExec <= memRdData[memCtlPkg::pteNoExecBit];
      memAddr   <= memAddr + 32'd4;
    end
    if ((state == memCtlPkg::stWalkSecond) && memDone)
    begin
      memAddr   <= {memRdData[memCtlPkg::pfnW-1:0], reqAddr[offsetW-1:0]};
      memIsRead <= reqIsRead;
    end
    if ((state == memCtlPkg::stAccess) && memDone && reqIsRead)
      rdData <= memRdData;
  end

  aRamCycleInRamState: assert property (@(posedge clk) disable iff (!rstN)
    (memStart || memDone) |-> (state == memCtlPkg::stAccess || state == memCtlPkg::stWalkFirst ||
                               state == memCtlPkg::stWalkSecond))
    else $error("RAM cycle outside a RAM state");

endmodule

// ==== verilog/memCtlTop.sv ====
`timescale 1ns/1ps

module memCtlTop #(
  parameter int ramLatency = 2,
  parameter int tlbEntries = 64
) (
  input  logic                clk,
  input  logic                rstN,
  input  logic                readReq,
  input  logic                writeReq,
  input  logic [31:0]         addr,
  input  logic [31:0]         wrData,
  input  logic                addrVirtual,
  input  logic                execMode,
  input  logic [31:0]         ptBase,
  output logic [31:0]         rdData,
  output memCtlPkg::mcStatusE status,
  input  logic [31:0]         phRdData,
  output logic [31:0]         phAddr,
  output logic [31:0]         phWrData,
  output logic                phReadReq,
  output logic                phWriteReq
);

  logic                       reqStart;
  logic                       reqFinish;
  logic [31:0]                reqAddr;
  logic [31:0]                reqData;
  logic                       reqIsRead;
  logic                       reqVirtual;
  logic                       reqExec;
  logic [31:0]                lookupAddr;
  logic                       hit;
  logic                       hitNoExec;
  logic [memCtlPkg::pfnW-1:0] hitPfn;
  logic                       fillEn;
  logic [memCtlPkg::vpnW-1:0] fillVpn;
  logic                       fillNoExec;
  logic [memCtlPkg::pfnW-1:0] fillPfn;
  logic                       memStart;
  logic [31:0]                memAddr;
  logic [31:0]                memData;
  logic                       memIsRead;
  logic                       memDone;
  logic [31:0]                memRdData;

  memReqLatch u_reqLatch (
    .clk(clk), .rstN(rstN), .readReq(readReq), .writeReq(writeReq), .addr(addr),
    .wrData(wrData), .addrVirtual(addrVirtual), .execMode(execMode),
    .reqFinish(reqFinish), .reqStart(reqStart), .reqAddr(reqAddr), .reqData(reqData),
    .reqIsRead(reqIsRead), .reqVirtual(reqVirtual), .reqExec(reqExec)
  );

  tlbCache #(.tlbEntries(tlbEntries)) u_tlb (
    .clk(clk), .rstN(rstN), .lookupAddr(lookupAddr), .fillEn(fillEn), .fillVpn(fillVpn),
    .fillNoExec(fillNoExec), .fillPfn(fillPfn), .hit(hit), .hitNoExec(hitNoExec),
    .hitPfn(hitPfn)
  );

  pageWalkFsm u_walker (
    .clk(clk), .rstN(rstN), .reqStart(reqStart), .reqAddr(reqAddr), .reqData(reqData),
    .reqIsRead(reqIsRead), .reqVirtual(reqVirtual), .reqExec(reqExec), .ptBase(ptBase),
    .hit(hit), .hitNoExec(hitNoExec), .hitPfn(hitPfn), .memDone(memDone),
    .memRdData(memRdData), .reqFinish(reqFinish), .lookupAddr(lookupAddr),
    .fillEn(fillEn), .fillVpn(fillVpn), .fillNoExec(fillNoExec), .fillPfn(fillPfn),
    .memStart(memStart), .memAddr(memAddr), .memData(memData), .memIsRead(memIsRead),
    .rdData(rdData), .status(status)
  );

  physMemPort #(.ramLatency(ramLatency)) u_memPort (
    .clk(clk), .rstN(rstN), .memStart(memStart), .memAddr(memAddr), .memData(memData),
    .memIsRead(memIsRead), .phRdData(phRdData), .memDone(memDone), .memRdData(memRdData),
    .phAddr(phAddr), .phWrData(phWrData), .phReadReq(phReadReq), .phWriteReq(phWriteReq)
  );

endmodule

// ==== verif/memCtlTb.sv ====
`timescale 1ns/1ps

module memCtlTb;

  localparam int ramLatency = 2;
  localparam int numRows    = 16;
  localparam int cycleLimit = 20 * numRows + 10; // reset cycles on top of the rows
  localparam logic [31:0] ptBaseAddr = 32'h0000_8000;
  localparam logic [31:0] staleWord  = 32'hdead_beef; // read bus value outside the data window
  localparam memCtlPkg::mcStatusE expDone  = memCtlPkg::statusDone;
  localparam memCtlPkg::mcStatusE expFault = memCtlPkg::statusFault;
  // request kinds as {write, virtual, exec}
  localparam logic [2:0] physRd = 3'b000;
  localparam logic [2:0] physWr = 3'b100;
  localparam logic [2:0] virtRd = 3'b010;
  localparam logic [2:0] virtWr = 3'b110;
  localparam logic [2:0] virtEx = 3'b011;
  // pages 0 and 1 both fold to TLB index 1, page 2 is no-execute, page 3 is invalid
  localparam logic [19:0] pageVpn [4] = '{20'h00001, 20'h01000, 20'h00002, 20'h00003};
  localparam logic pageNoExec [4] = '{1'b0, 1'b0, 1'b1, 1'b0};
  localparam logic pageValid [4]  = '{1'b1, 1'b1, 1'b1, 1'b0};

  logic                clk;
  logic                rstN;
  logic                readReq;
  logic                writeReq;
  logic [31:0]         addr;
  logic [31:0]         wrData;
  logic                addrVirtual;
  logic                execMode;
  logic [31:0]         ptBase;
  logic [31:0]         rdData;
  memCtlPkg::mcStatusE status;
  logic [31:0]         phRdData;
  logic [31:0]         phAddr;
  logic [31:0]         phWrData;
  logic                phReadReq;
  logic                phWriteReq;

  string               rowName [numRows];
  logic [2:0]          rowKind [numRows];
  logic [31:0]         rowAddr [numRows];
  logic [31:0]         rowData [numRows];
  memCtlPkg::mcStatusE rowStatus [numRows];
  logic [31:0]         rowExpData [numRows];
  int                  rowCount [numRows];
  int                  rowsAdded;
  logic [19:0]         pageFrame [4];
  logic [31:0]         ram [1024];
  logic [31:0]         strobeLog [64];
  int                  strobeTotal;
  int                  cycles = 0;
  logic [31:0]         lfsrState;

  memCtlTop #(.ramLatency(ramLatency), .tlbEntries(64)) u_dut (
    .clk(clk), .rstN(rstN), .readReq(readReq), .writeReq(writeReq), .addr(addr),
    .wrData(wrData), .addrVirtual(addrVirtual), .execMode(execMode), .ptBase(ptBase),
    .rdData(rdData), .status(status), .phRdData(phRdData), .phAddr(phAddr),
    .phWrData(phWrData), .phReadReq(phReadReq), .phWriteReq(phWriteReq)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit)
    begin
      $display("timeout: the requests did not finish within %0d cycles", cycleLimit);
      abortRun();
    end
  end

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32, 22, 2 and 1
  endfunction

  task automatic takeBits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsrState = lfsrStep(lfsrState);
      value = {value[30:0], lfsrState[0]};
    end
  endtask

  function automatic logic [31:0] fillWord(input logic [9:0] idx);
    return (32'h9e37_79b9 * {22'd0, idx}) ^ {idx, 12'h5a3, idx};
  endfunction

  function automatic logic [9:0] wordIdx(input logic [31:0] a);
    return a[11:2]; // the model decodes only these bits and repeats every 4 KB
  endfunction

  function automatic logic [31:0] pteAddr(input logic [19:0] vpn);
    return ptBaseAddr + 32'(vpn) * 32'd8;
  endfunction

  function automatic int pageSlot(input logic [19:0] vpn);
    for (int p = 0; p < 4; p++)
      if (pageVpn[p] == vpn)
        return p;
    return 0;
  endfunction

  // read data is valid only on the edge that comes ramLatency cycles after the strobe
  initial
  begin
    logic [31:0] frame;
    logic [9:0]  readIdx;
    int          readWait;
    lfsrState   = 32'he85da3ed;
    strobeTotal = 0;
    phRdData    = staleWord;
    readIdx     = '0;
    readWait    = 0;
    for (int i = 0; i < 1024; i++)
      ram[i] = fillWord(10'(i));
    for (int p = 0; p < 4; p++)
    begin
      takeBits(memCtlPkg::pfnW, frame);
      pageFrame[p] = frame[19:0];
      ram[wordIdx(pteAddr(pageVpn[p]))] = {pageValid[p], pageNoExec[p], 30'd0};
      ram[wordIdx(pteAddr(pageVpn[p]) + 32'd4)] = {12'd0, frame[19:0]};
    end
    forever
    begin
      @(negedge clk);
      phRdData = staleWord;
      if (readWait > 0)
      begin
        readWait--;
        if (readWait == 0)
          phRdData = ram[readIdx];
      end
      if (phReadReq || phWriteReq)
      begin
        strobeLog[strobeTotal] = phAddr;
        strobeTotal++;
      end
      if (phReadReq)
      begin
        readIdx  = wordIdx(phAddr);
        readWait = ramLatency - 1;
        if (readWait == 0)
          phRdData = ram[readIdx];
      end
      if (phWriteReq)
        ram[wordIdx(phAddr)] = phWrData;
    end
  end

  task automatic abortRun();
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  task automatic checkStatus(input string name, input memCtlPkg::mcStatusE expV,
                             input memCtlPkg::mcStatusE actV);
    if (actV !== expV)
    begin
      $display("ERROR %s: expected status %s, actual %s", name, expV.name(), actV.name());
      abortRun();
    end
  endtask

  task automatic checkData(input string name, input logic [31:0] expV, input logic [31:0] actV);
    if (actV !== expV)
    begin
      $display("ERROR %s: expected 0x%08h, actual 0x%08h", name, expV, actV);
      abortRun();
    end
  endtask

  task automatic checkCount(input string name, input int expV, input int actV);
    if (actV != expV)
    begin
      $display("ERROR %s: expected %0d RAM strobes, actual %0d", name, expV, actV);
      abortRun();
    end
  endtask

  task automatic addRow(input string name, input logic [2:0] kind, input logic [31:0] a,
                        input logic [31:0] d, input memCtlPkg::mcStatusE st,
                        input logic [31:0] expD, input int cnt);
    rowName[rowsAdded]    = name;
    rowKind[rowsAdded]    = kind;
    rowAddr[rowsAdded]    = a;
    rowData[rowsAdded]    = d;
    rowStatus[rowsAdded]  = st;
    rowExpData[rowsAdded] = expD;
    rowCount[rowsAdded]   = cnt;
    rowsAdded++;
  endtask

  task automatic buildTable();
    addRow("physWrite", physWr, 32'h0000_0200, 32'hcafe_0001, expDone, 32'h0, 1);
    addRow("physRead", physRd, 32'h0000_0200, 32'h0, expDone, 32'hcafe_0001, 1);
    addRow("virtReadWalkA", virtRd, 32'h0000_1100, 32'h0, expDone, fillWord(10'h040), 3);
    addRow("virtReadHitA", virtRd, 32'h0000_1104, 32'h0, expDone, fillWord(10'h041), 1);
    addRow("virtWriteHitA", virtWr, 32'h0000_1108, 32'h5a5a_1234, expDone, 32'h0, 1);
    addRow("virtReadBackA", virtRd, 32'h0000_1108, 32'h0, expDone, 32'h5a5a_1234, 1);
    addRow("virtReadWalkB", virtRd, 32'h0100_0180, 32'h0, expDone, fillWord(10'h060), 3);
    addRow("virtWriteHitB", virtWr, 32'h0100_0184, 32'h0bad_f00d, expDone, 32'h0, 1);
    addRow("virtReadEvictA", virtRd, 32'h0000_1108, 32'h0, expDone, 32'h5a5a_1234, 3);
    addRow("virtReadEvictB", virtRd, 32'h0100_0184, 32'h0, expDone, 32'h0bad_f00d, 3);
    addRow("execNoExecWalk", virtEx, 32'h0000_2200, 32'h0, expFault, 32'h0, 2);
    addRow("execNoExecHit", virtEx, 32'h0000_2200, 32'h0, expFault, 32'h0, 0);
    addRow("readNoExecPage", virtRd, 32'h0000_2300, 32'h0, expDone, fillWord(10'h0c0), 1);
    addRow("readInvalid", virtRd, 32'h0000_3000, 32'h0, expFault, 32'h0, 2);
    addRow("writeInvalid", virtWr, 32'h0000_3010, 32'h1111_2222, expFault, 32'h0, 2);
    addRow("execReadWalkA", virtEx, 32'h0000_1108, 32'h0, expDone, 32'h5a5a_1234, 3);
  endtask

  task automatic runRow(input int r);
    int          first;
    int          n;
    logic        sawBusy;
    logic [19:0] vpn;
    logic [31:0] expAddr [3];
    vpn = rowAddr[r][31:12];
    n = 0;
    if (rowKind[r][1] && rowCount[r] >= 2)
    begin
      expAddr[0] = pteAddr(vpn);
      expAddr[1] = pteAddr(vpn) + 32'd4;
      n = 2;
    end
    if (rowKind[r][1])
      expAddr[n] = {pageFrame[pageSlot(vpn)], rowAddr[r][11:0]};
    else
      expAddr[n] = rowAddr[r];
    @(negedge clk);
    first       = strobeTotal;
    addr        = rowAddr[r];
    wrData      = rowData[r];
    addrVirtual = rowKind[r][1];
    execMode    = rowKind[r][0];
    readReq     = !rowKind[r][2];
    writeReq    = rowKind[r][2];
    @(negedge clk);
    readReq  = 1'b0;
    writeReq = 1'b0;
    sawBusy  = 1'b0;
    while (!(sawBusy && status != memCtlPkg::statusBusy))
    begin
      @(negedge clk);
      if (status == memCtlPkg::statusBusy)
        sawBusy = 1'b1;
    end
    checkStatus(rowName[r], rowStatus[r], status);
    if (!rowKind[r][2] && rowStatus[r] == expDone)
      checkData(rowName[r], rowExpData[r], rdData);
    checkCount(rowName[r], rowCount[r], strobeTotal - first);
    for (int k = 0; k < rowCount[r]; k++)
      checkData($sformatf("%s strobe %0d", rowName[r], k), expAddr[k], strobeLog[first + k]);
  endtask

  initial
  begin
    rstN        = 1'b0;
    readReq     = 1'b0;
    writeReq    = 1'b0;
    addr        = '0;
    wrData      = '0;
    addrVirtual = 1'b0;
    execMode    = 1'b0;
    ptBase      = ptBaseAddr;
    rowsAdded   = 0;
    buildTable();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstN = 1'b1;
    checkStatus("afterReset", expDone, status);
    checkCount("afterReset", 0, strobeTotal);
    for (int r = 0; r < numRows; r++)
      runRow(r);
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== memCtl.f ====
verilog/memCtlPkg.sv
verilog/memReqLatch.sv
verilog/tlbCache.sv
verilog/physMemPort.sv
verilog/pageWalkFsm.sv
verilog/memCtlTop.sv
verif/memCtlTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= memCtlTb
FILELIST  ?= memCtl.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and check for a pass"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf $(BUILD_DIR)
